// File: hw/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// ----------------------------------------------------------------------
// block base addresses on the 12-bit I/O bus
// ----------------------------------------------------------------------
`define SPI_C_BASE        12'h100
`define SPI_D_BASE        12'h110
`define AF_BASE           12'h700

// ----------------------------------------------------------------------
// register offsets inside an SPI block
// ----------------------------------------------------------------------
`define SPI_OFF_PINS      4'd0     // bit-bang pins, reads lane inputs
`define SPI_OFF_START8    4'd1     // write starts an 8-bit transfer
`define SPI_OFF_START16   4'd2     // write starts a 16-bit transfer
`define SPI_OFF_IDLE      4'd3
`define SPI_OFF_DIR       4'd4     // quad lane direction, 1 = input
`define SPI_OFF_QUAD      4'd5

// ----------------------------------------------------------------------
// sample FIFO and pin reset
// ----------------------------------------------------------------------
`define AF_DEPTH          7'd64
`define AF_MAX_CREDITS    4'd8

// CS SCK IO3 IO2 MISO MOSI, chip select released
`define SPI_PIN_RESET     6'b100000

`endif

// File: hw/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // I/O bus
  typedef logic [11:0] io_addr_t;
  typedef logic [15:0] io_data_t;

  // low address bits, register select inside one block
  typedef logic [3:0]  reg_off_t;

  // IO3 IO2 MISO MOSI
  typedef logic [3:0]  spi_lanes_t;

  // CS SCK IO3 IO2 MISO MOSI, bit 5 down to bit 0
  typedef logic [5:0]  spi_pins_t;

  // FIFO pointers carry one wrap bit above the 64-entry index
  typedef logic [6:0]  af_count_t;

  // sink credits, 0 up to the cap of 8
  typedef logic [3:0]  af_credit_t;

endpackage

`default_nettype wire

// File: hw/spi_engine.sv
`default_nettype none
`timescale 1ns/1ps

module spi_engine (
  input  wire                      cpuclk_i,
  input  wire                      sckclock_i,
  input  wire                      start8_i,
  input  wire                      start16_i,
  input  wire periph_pkg::io_data_t   tx_i,
  input  wire                      quad_i,
  input  wire                      dir_i,
  input  wire periph_pkg::spi_lanes_t lanes_i,
  output periph_pkg::io_data_t     rx_o,
  output logic                     idle_o,
  output periph_pkg::spi_pins_t    pins_o,
  output periph_pkg::spi_lanes_t   oe_o
);

  import periph_pkg::*;

  logic       running;
  logic [4:0] counter;
  logic [4:0] counter_next;
  logic       sck;
  io_data_t   shifter;
  io_data_t   tx_swapped;
  spi_lanes_t lanes_out;

  // quad moves four bits per clock, so the counter steps by four
  assign counter_next = counter + (quad_i ? 5'd4 : 5'd1);
  assign tx_swapped   = {tx_i[7:0], tx_i[15:8]};    // low byte goes out first
  assign sck          = quad_i ? counter[2] : counter[0];

  // ----------------------------------------------------------------------
  // transfer control
  // ----------------------------------------------------------------------
  // 8-bit transfers start half way round, both end on the wrap to zero
  always_ff @(posedge cpuclk_i or posedge sckclock_i) begin
    if (sckclock_i) begin
      running <= 1'b0;
      counter <= 5'd0;
    end else if (start8_i) begin
      running <= 1'b1;
      counter <= 5'd16;
    end else if (start16_i) begin
      running <= 1'b1;
      counter <= 5'd0;
    end else if (running) begin
      running <= (counter_next != 5'd0);
      counter <= counter_next;
    end
  end

  // shift on the high half of sck
  always_ff @(posedge cpuclk_i) begin
    if (start8_i || start16_i) begin
      shifter <= tx_swapped;
    end else if (running && sck) begin
      if (quad_i) begin
        shifter <= {shifter[11:0], lanes_i};
      end else begin
        shifter <= {shifter[14:0], lanes_i[1]};   // MISO
      end
    end
  end

  // ----------------------------------------------------------------------
  // pad side
  // ----------------------------------------------------------------------
  assign lanes_out = quad_i ? shifter[15:12] : {3'b000, shifter[15]};

  // data lanes stay low between transfers so the bit-bang value shows
  assign pins_o = {1'b0, sck, running ? lanes_out : 4'b0000};

  // single mode always listens on MISO, quad follows dir
  assign oe_o   = quad_i ? {4{~dir_i}} : 4'b1101;

  assign idle_o = ~running;
  assign rx_o   = shifter;

endmodule

`default_nettype wire

// File: hw/spi_channel.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_consts.svh"

module spi_channel (
  input  wire                         cpuclk_i,
  input  wire                         sckclock_i,
  input  wire                         sel_i,
  input  wire                         io_w_i,
  input  wire periph_pkg::reg_off_t   reg_off_i,
  input  wire periph_pkg::io_data_t   io_wd_i,
  input  wire periph_pkg::spi_lanes_t lanes_i,
  output periph_pkg::io_data_t        rdata_o,
  output logic                        cs_o,
  output logic                        sck_o,
  output periph_pkg::spi_lanes_t      lanes_o,
  output periph_pkg::spi_lanes_t      lanes_oe_o
);

  import periph_pkg::*;

  logic       wr;
  logic       start8;
  logic       start16;
  logic       dir;
  logic       quad;
  spi_pins_t  pin_reg;        // bit-bang pins
  spi_pins_t  eng_pins;
  spi_pins_t  pad_out;
  io_data_t   eng_rx;
  logic       eng_idle;

  assign wr      = sel_i & io_w_i;
  assign start8  = wr & (reg_off_i == `SPI_OFF_START8);
  assign start16 = wr & (reg_off_i == `SPI_OFF_START16);

  // ----------------------------------------------------------------------
  // control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge cpuclk_i or posedge sckclock_i) begin
    if (sckclock_i) begin
      pin_reg <= `SPI_PIN_RESET;
      dir     <= 1'b0;
      quad    <= 1'b0;
    end else if (wr) begin
      case (reg_off_i)
        `SPI_OFF_PINS: pin_reg <= io_wd_i[5:0];
        `SPI_OFF_DIR:  dir     <= io_wd_i[0];
        `SPI_OFF_QUAD: quad    <= io_wd_i[0];
        default: ;                               // starts go to the engine
      endcase
    end
  end

  spi_engine spi_engine_inst (
    .cpuclk_i   (cpuclk_i),
    .sckclock_i (sckclock_i),
    .start8_i   (start8),
    .start16_i  (start16),
    .tx_i       (io_wd_i),
    .quad_i     (quad),
    .dir_i      (dir),
    .lanes_i    (lanes_i),
    .rx_o       (eng_rx),
    .idle_o     (eng_idle),
    .pins_o     (eng_pins),
    .oe_o       (lanes_oe_o)
  );

  // bit-bang and engine share the pads
  assign pad_out = pin_reg | eng_pins;
  assign cs_o    = pad_out[5];
  assign sck_o   = pad_out[4];
  assign lanes_o = pad_out[3:0];

  // ----------------------------------------------------------------------
  // read data, valid for the current offset whether selected or not
  // ----------------------------------------------------------------------
  always_comb begin
    case (reg_off_i)
      `SPI_OFF_PINS:    rdata_o = {12'd0, lanes_i};
      `SPI_OFF_START8,
      `SPI_OFF_START16: rdata_o = eng_rx;
      `SPI_OFF_IDLE:    rdata_o = {15'd0, eng_idle};
      default:          rdata_o = 16'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/audio_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_consts.svh"

module audio_fifo (
  input  wire                       cpuclk_i,
  input  wire                       sckclock_i,
  input  wire                       sel_i,
  input  wire                       io_w_i,
  input  wire periph_pkg::io_data_t io_wd_i,
  input  wire                       credit_i,
  output periph_pkg::io_data_t      rdata_o,
  output periph_pkg::io_data_t      sample_o,
  output logic                      sample_valid_o
);

  import periph_pkg::*;

  io_data_t   mem [0:`AF_DEPTH-1];
  af_count_t  wr_ptr;
  af_count_t  rd_ptr;
  af_count_t  fill;
  af_count_t  space;
  af_credit_t credits;
  logic       full;
  logic       empty;
  logic       push;
  logic       pop;
  logic       grant;

  assign fill  = wr_ptr - rd_ptr;        // wrap bit keeps full and empty apart
  assign full  = (fill == `AF_DEPTH);
  assign empty = (fill == 7'd0);
  assign space = `AF_DEPTH - fill;

  assign rdata_o = {9'd0, space};

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------
  assign push = sel_i & io_w_i & ~full;   // dropped when full

  always_ff @(posedge cpuclk_i) begin
    if (push) begin
      mem[wr_ptr[5:0]] <= io_wd_i;
    end
  end

  always_ff @(posedge cpuclk_i or posedge sckclock_i) begin
    if (sckclock_i) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 7'd1;
    end
  end

  // ----------------------------------------------------------------------
  // credit counter and output stage
  // ----------------------------------------------------------------------
  assign grant = credit_i & (credits != `AF_MAX_CREDITS);  // saturate at cap
  assign pop   = (credits != 4'd0) & ~empty;

  always_ff @(posedge cpuclk_i or posedge sckclock_i) begin
    if (sckclock_i) begin
      credits        <= '0;
      rd_ptr         <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      credits        <= credits + {3'b000, grant} - {3'b000, pop};
      sample_valid_o <= pop;                          // one sample per credit
      if (pop) begin
        rd_ptr <= rd_ptr + 7'd1;
      end
    end
  end

  // head of the queue, held until the next pop
  always_ff @(posedge cpuclk_i) begin
    if (pop) begin
      sample_o <= mem[rd_ptr[5:0]];
    end
  end

endmodule

`default_nettype wire

// File: hw/io_decoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_consts.svh"

module io_decoder (
  input  wire                       cpuclk_i,
  input  wire                       sckclock_i,
  input  wire                       io_r_i,
  input  wire periph_pkg::io_addr_t io_a_i,
  input  wire periph_pkg::io_data_t spi_c_rdata_i,
  input  wire periph_pkg::io_data_t spi_d_rdata_i,
  input  wire periph_pkg::io_data_t af_rdata_i,
  output logic                      spi_c_sel_o,
  output logic                      spi_d_sel_o,
  output logic                      af_sel_o,
  output periph_pkg::reg_off_t      reg_off_o,
  output periph_pkg::io_data_t      io_rd_o,
  output logic                      io_rvalid_o
);

  import periph_pkg::*;

  io_data_t rd_next;

  // ----------------------------------------------------------------------
  // block select
  // ----------------------------------------------------------------------
  // SPI blocks own sixteen addresses each, the FIFO only its base
  assign spi_c_sel_o = ({io_a_i[11:4], 4'h0} == `SPI_C_BASE);
  assign spi_d_sel_o = ({io_a_i[11:4], 4'h0} == `SPI_D_BASE);
  assign af_sel_o    = (io_a_i == `AF_BASE);
  assign reg_off_o   = io_a_i[3:0];

  always_comb begin
    if (spi_c_sel_o) begin
      rd_next = spi_c_rdata_i;
    end else if (spi_d_sel_o) begin
      rd_next = spi_d_rdata_i;
    end else if (af_sel_o) begin
      rd_next = af_rdata_i;
    end else begin
      rd_next = 16'd0;                  // unmapped
    end
  end

  // ----------------------------------------------------------------------
  // read return, one cycle after the request
  // ----------------------------------------------------------------------
  always_ff @(posedge cpuclk_i or posedge sckclock_i) begin
    if (sckclock_i) begin
      io_rvalid_o <= 1'b0;
    end else begin
      io_rvalid_o <= io_r_i;
    end
  end

  always_ff @(posedge cpuclk_i) begin
    if (io_r_i) begin
      io_rd_o <= rd_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/periph_top.sv
`default_nettype none
`timescale 1ns/1ps

module periph_top (
  input  wire                         cpuclk_i,
  input  wire                         sckclock_i,

  // I/O bus
  input  wire                         io_w_i,
  input  wire                         io_r_i,
  input  wire periph_pkg::io_addr_t   io_a_i,
  input  wire periph_pkg::io_data_t   io_wd_i,
  output wire periph_pkg::io_data_t   io_rd_o,
  output wire                         io_rvalid_o,

  // SPI channel c
  output wire                         spi_c_cs_o,
  output wire                         spi_c_sck_o,
  output wire periph_pkg::spi_lanes_t spi_c_lanes_o,
  output wire periph_pkg::spi_lanes_t spi_c_lanes_oe_o,
  input  wire periph_pkg::spi_lanes_t spi_c_lanes_i,

  // SPI channel d
  output wire                         spi_d_cs_o,
  output wire                         spi_d_sck_o,
  output wire periph_pkg::spi_lanes_t spi_d_lanes_o,
  output wire periph_pkg::spi_lanes_t spi_d_lanes_oe_o,
  input  wire periph_pkg::spi_lanes_t spi_d_lanes_i,

  // sample output, credit flow control
  input  wire                         credit_i,
  output wire periph_pkg::io_data_t   sample_o,
  output wire                         sample_valid_o
);

  import periph_pkg::*;

  logic     spi_c_sel;
  logic     spi_d_sel;
  logic     af_sel;
  reg_off_t reg_off;
  io_data_t spi_c_rdata;
  io_data_t spi_d_rdata;
  io_data_t af_rdata;

  io_decoder io_decoder_inst (
    .cpuclk_i      (cpuclk_i),
    .sckclock_i    (sckclock_i),
    .io_r_i        (io_r_i),
    .io_a_i        (io_a_i),
    .spi_c_rdata_i (spi_c_rdata),
    .spi_d_rdata_i (spi_d_rdata),
    .af_rdata_i    (af_rdata),
    .spi_c_sel_o   (spi_c_sel),
    .spi_d_sel_o   (spi_d_sel),
    .af_sel_o      (af_sel),
    .reg_off_o     (reg_off),
    .io_rd_o       (io_rd_o),
    .io_rvalid_o   (io_rvalid_o)
  );

  // ----------------------------------------------------------------------
  // SPI channels at 0x100 and 0x110
  // ----------------------------------------------------------------------
  spi_channel spi_c_inst (
    .cpuclk_i   (cpuclk_i),
    .sckclock_i (sckclock_i),
    .sel_i      (spi_c_sel),
    .io_w_i     (io_w_i),
    .reg_off_i  (reg_off),
    .io_wd_i    (io_wd_i),
    .lanes_i    (spi_c_lanes_i),
    .rdata_o    (spi_c_rdata),
    .cs_o       (spi_c_cs_o),
    .sck_o      (spi_c_sck_o),
    .lanes_o    (spi_c_lanes_o),
    .lanes_oe_o (spi_c_lanes_oe_o)
  );

  spi_channel spi_d_inst (
    .cpuclk_i   (cpuclk_i),
    .sckclock_i (sckclock_i),
    .sel_i      (spi_d_sel),
    .io_w_i     (io_w_i),
    .reg_off_i  (reg_off),
    .io_wd_i    (io_wd_i),
    .lanes_i    (spi_d_lanes_i),
    .rdata_o    (spi_d_rdata),
    .cs_o       (spi_d_cs_o),
    .sck_o      (spi_d_sck_o),
    .lanes_o    (spi_d_lanes_o),
    .lanes_oe_o (spi_d_lanes_oe_o)
  );

  audio_fifo audio_fifo_inst (
    .cpuclk_i       (cpuclk_i),
    .sckclock_i     (sckclock_i),
    .sel_i          (af_sel),
    .io_w_i         (io_w_i),
    .io_wd_i        (io_wd_i),
    .credit_i       (credit_i),
    .rdata_o        (af_rdata),
    .sample_o       (sample_o),
    .sample_valid_o (sample_valid_o)
  );

endmodule

`default_nettype wire

// File: dv/periph_assertions.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_consts.svh"

module periph_assertions (
  input wire cpuclk_i,
  input wire sckclock_i,
  input wire io_r_i,
  input wire io_rvalid_i,
  input wire credit_i,
  input wire sample_valid_i
);

  logic [4:0] outstanding;   // credits granted, not yet answered by a sample

  always_ff @(posedge cpuclk_i or posedge sckclock_i) begin
    if (sckclock_i) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + {4'd0, credit_i} - {4'd0, sample_valid_i};
    end
  end

  // ----------------------------------------------------------------------
  // bus and sample handshakes
  // ----------------------------------------------------------------------
  a_read_return : assert property (@(posedge cpuclk_i) disable iff (sckclock_i)
    io_rvalid_i == $past(io_r_i))
    else $error("read valid does not follow the read strobe by one cycle");

  a_sample_needs_credit : assert property (@(posedge cpuclk_i) disable iff (sckclock_i)
    sample_valid_i |-> (outstanding != 5'd0))
    else $error("sample sent with no credit outstanding");

  a_credit_cap : assert property (@(posedge cpuclk_i) disable iff (sckclock_i)
    credit_i |-> (outstanding < {1'b0, `AF_MAX_CREDITS}))
    else $error("credit granted while the sink is already at the cap");

endmodule

bind periph_top periph_assertions periph_assertions_inst (
  .cpuclk_i       (cpuclk_i),
  .sckclock_i     (sckclock_i),
  .io_r_i         (io_r_i),
  .io_rvalid_i    (io_rvalid_o),
  .credit_i       (credit_i),
  .sample_valid_i (sample_valid_o)
);

`default_nettype wire

// File: dv/periph_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_consts.svh"

module periph_tb;

  import periph_pkg::*;

  // about twenty times the length of the five tests
  localparam int TIMEOUT_CYCLES = 6000;

  logic       cpuclk;
  logic       sckclock;
  logic       io_w;
  logic       io_r;
  io_addr_t   io_a;
  io_data_t   io_wd;
  io_data_t   io_rd;
  logic       io_rvalid;
  logic       spi_c_cs;
  logic       spi_c_sck;
  spi_lanes_t spi_c_lanes_o;
  spi_lanes_t spi_c_lanes_oe;
  spi_lanes_t spi_c_lanes;
  logic       spi_d_cs;
  logic       spi_d_sck;
  spi_lanes_t spi_d_lanes_o;
  spi_lanes_t spi_d_lanes_oe;
  spi_lanes_t spi_d_lanes;
  logic       credit;
  io_data_t   sample;
  logic       sample_valid;

  logic [1:0] loop_mode;      // 0 driven, 1 c MOSI to MISO, 2 d quad lanes
  spi_lanes_t c_drv;
  spi_lanes_t d_drv;
  int         errors;
  int         checks;
  int         tests;
  int         cycle_count;
  io_data_t   exp_q[$];
  io_data_t   got_q[$];

  assign spi_c_lanes = (loop_mode == 2'd1) ? {2'b00, spi_c_lanes_o[0], 1'b0} : c_drv;
  assign spi_d_lanes = (loop_mode == 2'd2) ? spi_d_lanes_o : d_drv;

  periph_top periph_top_inst (
    .cpuclk_i (cpuclk), .sckclock_i (sckclock),
    .io_w_i (io_w), .io_r_i (io_r), .io_a_i (io_a), .io_wd_i (io_wd),
    .io_rd_o (io_rd), .io_rvalid_o (io_rvalid),
    .spi_c_cs_o (spi_c_cs), .spi_c_sck_o (spi_c_sck), .spi_c_lanes_o (spi_c_lanes_o),
    .spi_c_lanes_oe_o (spi_c_lanes_oe), .spi_c_lanes_i (spi_c_lanes),
    .spi_d_cs_o (spi_d_cs), .spi_d_sck_o (spi_d_sck), .spi_d_lanes_o (spi_d_lanes_o),
    .spi_d_lanes_oe_o (spi_d_lanes_oe), .spi_d_lanes_i (spi_d_lanes),
    .credit_i (credit), .sample_o (sample), .sample_valid_o (sample_valid)
  );

  initial begin
    cpuclk = 1'b0;
    forever #20 cpuclk = ~cpuclk;
  end

  always @(posedge cpuclk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // sink samples on the falling edge
  always @(negedge cpuclk) begin
    if (!sckclock && sample_valid) got_q.push_back(sample);
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic check_eq(input io_data_t got, input io_data_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL @ %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic io_addr_t reg_addr(input io_addr_t base, input reg_off_t off);
    return {base[11:4], off};
  endfunction

  function automatic io_data_t random_word();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  task automatic bus_write(input io_addr_t addr, input io_data_t data);
    io_w  = 1'b1;
    io_a  = addr;
    io_wd = data;
    @(posedge cpuclk);
    #2;
    io_w = 1'b0;
  endtask

  task automatic bus_read(input io_addr_t addr, output io_data_t data);
    int n;
    io_r = 1'b1;
    io_a = addr;
    @(posedge cpuclk);
    #2;
    io_r = 1'b0;
    n = 0;
    while (!io_rvalid && n < 4) begin
      @(posedge cpuclk);
      #2;
      n++;
    end
    if (!io_rvalid) begin
      errors++;
      $display("error: read at %h got no valid response", addr);
    end
    data = io_rd;
  endtask

  task automatic pulse_credit();
    credit = 1'b1;
    @(posedge cpuclk);
    #2;
    credit = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests++;
    $display("test %s: %0d errors", name, errors - errs_at_start);
  endtask

  // start a transfer, count idle reads of 0, then read the received word
  task automatic run_transfer(input io_addr_t base, input reg_off_t start_off,
                              input io_data_t tx, input int exp_busy,
                              input io_data_t exp_rx, input string what);
    int       busy;
    io_data_t d;
    bus_write(reg_addr(base, start_off), tx);
    busy = 0;
    bus_read(reg_addr(base, `SPI_OFF_IDLE), d);
    while (d[0] == 1'b0 && busy < 64) begin
      busy++;
      bus_read(reg_addr(base, `SPI_OFF_IDLE), d);
    end
    if (d[0] == 1'b0) begin
      errors++;
      $display("error: %s transfer never went idle", what);
    end else begin
      check_eq(busy[15:0], exp_busy[15:0], {what, " busy cycles"});
    end
    bus_read(reg_addr(base, `SPI_OFF_START8), d);
    check_eq(d, exp_rx, {what, " received word"});
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic reset_state_test();
    int       e0;
    io_data_t d;
    e0 = errors;
    check_eq({15'd0, spi_c_cs}, 16'd1, "channel c cs after reset");
    check_eq({15'd0, spi_c_sck}, 16'd0, "channel c sck after reset");
    check_eq({15'd0, spi_d_cs}, 16'd1, "channel d cs after reset");
    check_eq({15'd0, spi_d_sck}, 16'd0, "channel d sck after reset");
    bus_read(reg_addr(`SPI_C_BASE, `SPI_OFF_IDLE), d);
    check_eq(d, 16'd1, "channel c idle after reset");
    bus_read(reg_addr(`SPI_D_BASE, `SPI_OFF_IDLE), d);
    check_eq(d, 16'd1, "channel d idle after reset");
    bus_read(`AF_BASE, d);
    check_eq(d, 16'd64, "fifo space after reset");
    bus_read(12'h200, d);
    check_eq(d, 16'd0, "unmapped read at 0x200");
    bus_read(12'h701, d);                       // FIFO answers at its base only
    check_eq(d, 16'd0, "unmapped read at 0x701");
    bus_read(12'h10f, d);
    check_eq(d, 16'd0, "unused spi offset 0xf");
    report_test("reset_state", e0);
  endtask

  task automatic single_loopback_test();
    int       e0;
    io_data_t tx;
    e0 = errors;
    loop_mode = 2'd1;
    check_eq({12'd0, spi_c_lanes_oe}, 16'h000d, "single mode lane enables");
    tx = random_word();
    run_transfer(`SPI_C_BASE, `SPI_OFF_START8, tx, 16, tx, "c single 8-bit");
    tx = random_word();
    run_transfer(`SPI_C_BASE, `SPI_OFF_START16, tx, 32, {tx[7:0], tx[15:8]},
                 "c single 16-bit");
    check_eq({15'd0, spi_c_sck}, 16'd0, "channel c sck low after transfer");
    loop_mode = 2'd0;
    report_test("single_loopback", e0);
  endtask

  task automatic quad_loopback_test();
    int       e0;
    io_data_t tx;
    e0 = errors;
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_QUAD), 16'd1);
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_DIR), 16'd0);
    loop_mode = 2'd2;
    check_eq({12'd0, spi_d_lanes_oe}, 16'h000f, "quad dir 0 lane enables");
    tx = random_word();
    run_transfer(`SPI_D_BASE, `SPI_OFF_START16, tx, 8, {tx[7:0], tx[15:8]},
                 "d quad 16-bit");
    tx = random_word();
    run_transfer(`SPI_D_BASE, `SPI_OFF_START8, tx, 4, tx, "d quad 8-bit");
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_DIR), 16'd1);
    check_eq({12'd0, spi_d_lanes_oe}, 16'h0000, "quad dir 1 lane enables");
    loop_mode = 2'd0;
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_DIR), 16'd0);
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_QUAD), 16'd0);
    report_test("quad_loopback", e0);
  endtask

  task automatic bitbang_test();
    int          e0;
    io_data_t    d;
    logic [31:0] r;
    e0 = errors;
    bus_write(reg_addr(`SPI_C_BASE, `SPI_OFF_PINS), 16'h001a);   // cs 0 sck 1 lanes 1010
    check_eq({15'd0, spi_c_cs}, 16'd0, "channel c bit-bang cs");
    check_eq({15'd0, spi_c_sck}, 16'd1, "channel c bit-bang sck");
    check_eq({12'd0, spi_c_lanes_o}, 16'h000a, "channel c bit-bang lanes");
    bus_write(reg_addr(`SPI_C_BASE, `SPI_OFF_PINS), 16'h0020);
    check_eq({15'd0, spi_c_cs}, 16'd1, "channel c cs released");
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_PINS), 16'h0015);   // cs 0 sck 1 lanes 0101
    check_eq({15'd0, spi_d_cs}, 16'd0, "channel d bit-bang cs");
    check_eq({15'd0, spi_d_sck}, 16'd1, "channel d bit-bang sck");
    check_eq({12'd0, spi_d_lanes_o}, 16'h0005, "channel d bit-bang lanes");
    bus_write(reg_addr(`SPI_D_BASE, `SPI_OFF_PINS), 16'h0020);
    check_eq({15'd0, spi_d_cs}, 16'd1, "channel d cs released");
    // pin-input register follows whatever the pads see
    r = $urandom;
    c_drv = r[3:0];
    d_drv = r[7:4];
    bus_read(reg_addr(`SPI_C_BASE, `SPI_OFF_PINS), d);
    check_eq(d, {12'd0, c_drv}, "channel c pin read");
    bus_read(reg_addr(`SPI_D_BASE, `SPI_OFF_PINS), d);
    check_eq(d, {12'd0, d_drv}, "channel d pin read");
    report_test("bitbang", e0);
  endtask

  task automatic audio_credits_test();
    int       e0;
    int       i;
    int       n;
    int       exp_n;
    int       got_n;
    int       exp_space;
    io_data_t d;
    e0 = errors;
    for (i = 0; i < 12; i++) begin
      d = random_word();
      bus_write(`AF_BASE, d);
      exp_q.push_back(d);
      bus_read(`AF_BASE, d);
      exp_space = 63 - i;
      check_eq(d, exp_space[15:0], "fifo space after write");
    end
    repeat (10) @(posedge cpuclk);
    #2;
    got_n = got_q.size();
    check_eq(got_n[15:0], 16'd0, "samples out before any credit");
    for (i = 0; i < 12; i++) begin
      pulse_credit();
      n = 0;
      while (got_q.size() <= i && n < 16) begin
        @(posedge cpuclk);
        #2;
        n++;
      end
      if (got_q.size() <= i) begin
        errors++;
        $display("error: no sample left after credit %0d", i);
      end else begin
        check_eq(got_q[i], exp_q[i], "sample order");
      end
      repeat (2) @(posedge cpuclk);
      #2;
      got_n = got_q.size();
      exp_n = i + 1;
      check_eq(got_n[15:0], exp_n[15:0], "samples per credit");
    end
    bus_read(`AF_BASE, d);
    check_eq(d, 16'd64, "fifo space after draining");
    report_test("audio_credits", e0);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    io_w      = 1'b0;
    io_r      = 1'b0;
    io_a      = '0;
    io_wd     = '0;
    credit    = 1'b0;
    loop_mode = 2'd0;
    c_drv     = '0;
    d_drv     = '0;
    sckclock  = 1'b1;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    void'($urandom(47));
    repeat (8) @(posedge cpuclk);
    #2;
    sckclock = 1'b0;
    @(posedge cpuclk);
    #2;
    reset_state_test();
    single_loopback_test();
    quad_loopback_test();
    bitbang_test();
    audio_credits_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/periph_pkg.sv
hw/spi_engine.sv
hw/spi_channel.sv
hw/audio_fifo.sv
hw/io_decoder.sv
hw/periph_top.sv
dv/periph_assertions.sv
dv/periph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the periph_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -j 0 --top-module periph_tb \
  -f build.f -o periph_sim 2>&1 && ./obj_dir/periph_sim 2>&1)
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
